//--- run_sim.sh
#!/bin/sh
# Build the crossbar testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module xbar_tb -f verilog.f --Mdir obj_dir -o xbar_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/xbar_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- src/link_to_crossbar.sv
`timescale 1ns/1ps

module link_to_crossbar (
  // Tile side
  input  logic [xbar_pkg::num_in-1:0]                            link_v_i,
  input  logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_i,
  output logic [xbar_pkg::num_in-1:0]                            link_ready_o,
  output logic [xbar_pkg::num_in-1:0]                            link_v_o,
  output logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_o,
  input  logic [xbar_pkg::num_in-1:0]                            link_ready_i,
  // Crossbar side
  output logic [xbar_pkg::num_in-1:0]                            in_v_o,
  output logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] in_data_o,
  input  logic [xbar_pkg::num_in-1:0]                            in_ready_i,
  input  logic [xbar_pkg::num_in-1:0]                            out_v_i,
  input  logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] out_data_i,
  output logic [xbar_pkg::num_in-1:0]                            out_ready_o
);

  logic [xbar_pkg::num_in-1:0][xbar_pkg::x_cord_width-1:0] x_cord_in;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::y_cord_width-1:0] y_cord_in;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::lg_num_in-1:0]    dest_idx;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::x_cord_width-1:0] x_cord_out;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::y_cord_width-1:0] y_cord_out;

  for (genvar y = 0; y < xbar_pkg::num_in_y; y++) begin : g_row
    for (genvar x = 0; x < xbar_pkg::num_in_x; x++) begin : g_col
      localparam int lane = y * xbar_pkg::num_in_x + x;

      // Tile to crossbar: coordinates become a flat port index
      assign x_cord_in[lane] = link_data_i[lane][0+:xbar_pkg::x_cord_width];
      assign y_cord_in[lane] =
        link_data_i[lane][xbar_pkg::x_cord_width+:xbar_pkg::y_cord_width];
      assign dest_idx[lane] = (xbar_pkg::lg_num_in)'(
        int'(x_cord_in[lane]) + int'(y_cord_in[lane]) * xbar_pkg::num_in_x);

      assign in_data_o[lane] = {
        link_data_i[lane][xbar_pkg::link_width-1:
                          xbar_pkg::x_cord_width+xbar_pkg::y_cord_width],
        dest_idx[lane]
      };
      assign in_v_o[lane]       = link_v_i[lane];
      assign link_ready_o[lane] = in_ready_i[lane];

      // Crossbar to tile: split the index back into x and y
      assign x_cord_out[lane] = (xbar_pkg::x_cord_width)'(
        int'(out_data_i[lane][xbar_pkg::lg_num_in-1:0]) % xbar_pkg::num_in_x);
      assign y_cord_out[lane] = (xbar_pkg::y_cord_width)'(
        int'(out_data_i[lane][xbar_pkg::lg_num_in-1:0]) / xbar_pkg::num_in_x);

      assign link_data_o[lane] = {
        out_data_i[lane][xbar_pkg::xbar_width-1:xbar_pkg::lg_num_in],
        y_cord_out[lane],
        x_cord_out[lane]
      };
      assign link_v_o[lane]    = out_v_i[lane];
      assign out_ready_o[lane] = link_ready_i[lane];
    end
  end

endmodule

//--- src/manycore_xbar_top.sv
`timescale 1ns/1ps

module manycore_xbar_top (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  // Tile to crossbar
  input  logic [xbar_pkg::num_in-1:0]                            link_v_i,
  input  logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_i,
  output logic [xbar_pkg::num_in-1:0]                            link_ready_o,
  // Crossbar to tile
  output logic [xbar_pkg::num_in-1:0]                            link_v_o,
  output logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_o,
  input  logic [xbar_pkg::num_in-1:0]                            link_ready_i
);

  logic [xbar_pkg::num_in-1:0]                            in_v;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] in_data;
  logic [xbar_pkg::num_in-1:0]                            in_ready;
  logic [xbar_pkg::num_in-1:0]                            head_v;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] head_data;
  logic [xbar_pkg::num_in-1:0]                            head_yumi;
  logic [xbar_pkg::num_in-1:0]                            out_v;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] out_data;
  logic [xbar_pkg::num_in-1:0]                            out_ready;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::num_in-1:0]     arb_reqs;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::num_in-1:0]     arb_grants;
  logic [xbar_pkg::num_in-1:0]                            arb_accept;

  link_to_crossbar adapter (
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i),
    .in_v_o       (in_v),
    .in_data_o    (in_data),
    .in_ready_i   (in_ready),
    .out_v_i      (out_v),
    .out_data_i   (out_data),
    .out_ready_o  (out_ready)
  );

  // One buffer per input and one arbiter per output
  for (genvar p = 0; p < xbar_pkg::num_in; p++) begin : g_port
    xbar_fifo #(.els_p(xbar_pkg::fifo_els)) in_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (in_v[p]),
      .data_i  (in_data[p]),
      .ready_o (in_ready[p]),
      .v_o     (head_v[p]),
      .data_o  (head_data[p]),
      .yumi_i  (head_yumi[p])
    );

    xbar_rr_arbiter #(.inputs_p(xbar_pkg::num_in)) out_arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .reqs_i   (arb_reqs[p]),
      .accept_i (arb_accept[p]),
      .grants_o (arb_grants[p])
    );
  end

  xbar_switch xbar (
    .head_v_i     (head_v),
    .head_data_i  (head_data),
    .head_yumi_o  (head_yumi),
    .out_v_o      (out_v),
    .out_data_o   (out_data),
    .out_ready_i  (out_ready),
    .arb_reqs_o   (arb_reqs),
    .arb_grants_i (arb_grants),
    .arb_accept_o (arb_accept)
  );

endmodule

//--- src/xbar_fifo.sv
`timescale 1ns/1ps

module xbar_fifo #(
  parameter int els_p = xbar_pkg::fifo_els
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            v_i,
  input  logic [xbar_pkg::xbar_width-1:0] data_i,
  output logic                            ready_o,
  output logic                            v_o,
  output logic [xbar_pkg::xbar_width-1:0] data_o,
  input  logic                            yumi_i
);

  logic [xbar_pkg::xbar_width-1:0] mem_r [els_p];
  logic [$clog2(els_p)-1:0]        wptr_r;
  logic [$clog2(els_p)-1:0]        rptr_r;
  logic [$clog2(els_p+1)-1:0]      count_r;
  logic                            enq;
  logic                            deq;

  function automatic logic [$clog2(els_p)-1:0] next_ptr(input logic [$clog2(els_p)-1:0] ptr);
    if (ptr == ($clog2(els_p))'(els_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Ready depends only on occupancy, never on yumi
  assign ready_o = (count_r != ($clog2(els_p+1))'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (deq) begin
        rptr_r <= next_ptr(rptr_r);
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // The switch only pops a head that is actually there
  a_no_yumi_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  // A waiting head stays put until it is taken
  a_head_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(data_o)));

endmodule

//--- src/xbar_pkg.sv
package xbar_pkg;

  // Array geometry
  localparam int num_in_x = 2;
  localparam int num_in_y = 2;
  localparam int num_in = num_in_x * num_in_y;
  localparam int lg_num_in = $clog2(num_in);

  // Coordinate fields at the bottom of a tile-link word
  localparam int x_cord_width = 1;
  localparam int y_cord_width = 1;

  // Word widths
  localparam int link_width = 16;
  localparam int xbar_width = link_width - x_cord_width - y_cord_width + lg_num_in;

  // Input buffer depth
  localparam int fifo_els = 2;

endpackage

//--- src/xbar_rr_arbiter.sv
`timescale 1ns/1ps

module xbar_rr_arbiter #(
  parameter int inputs_p = xbar_pkg::num_in
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [inputs_p-1:0] reqs_i,
  input  logic                accept_i,
  output logic [inputs_p-1:0] grants_o
);

  logic [xbar_pkg::lg_num_in-1:0] ptr_r;
  logic [xbar_pkg::lg_num_in-1:0] grant_idx;
  logic                           found;

  // First requester at or after the pointer wins
  always_comb begin
    logic [xbar_pkg::lg_num_in-1:0] cand;
    grants_o  = '0;
    grant_idx = ptr_r;
    found     = 1'b0;
    for (int k = 0; k < inputs_p; k++) begin
      cand = (xbar_pkg::lg_num_in)'((int'(ptr_r) + k) % inputs_p);
      if (!found && reqs_i[cand]) begin
        found           = 1'b1;
        grant_idx       = cand;
        grants_o[cand]  = 1'b1;
      end
    end
  end

  // An unaccepted grant parks the pointer on the winner, so it holds
  // even if a new request shows up ahead of it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (accept_i) begin
      if (grant_idx == (xbar_pkg::lg_num_in)'(inputs_p - 1)) begin
        ptr_r <= '0;
      end else begin
        ptr_r <= grant_idx + 1'b1;
      end
    end else if (found) begin
      ptr_r <= grant_idx;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grants_o) && ((grants_o == '0) == (reqs_i == '0)));

  // Relies on the buffer head holding its request until popped
  a_grant_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (found && !accept_i) |=> (grants_o == $past(grants_o)));

endmodule

//--- src/xbar_switch.sv
`timescale 1ns/1ps

module xbar_switch (
  // Buffer heads
  input  logic [xbar_pkg::num_in-1:0]                            head_v_i,
  input  logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] head_data_i,
  output logic [xbar_pkg::num_in-1:0]                            head_yumi_o,
  // Outputs toward the tiles
  output logic [xbar_pkg::num_in-1:0]                            out_v_o,
  output logic [xbar_pkg::num_in-1:0][xbar_pkg::xbar_width-1:0] out_data_o,
  input  logic [xbar_pkg::num_in-1:0]                            out_ready_i,
  // Arbiters, indexed by output then input
  output logic [xbar_pkg::num_in-1:0][xbar_pkg::num_in-1:0]     arb_reqs_o,
  input  logic [xbar_pkg::num_in-1:0][xbar_pkg::num_in-1:0]     arb_grants_i,
  output logic [xbar_pkg::num_in-1:0]                            arb_accept_o
);

  // Each head asks for exactly the output named in its index field
  for (genvar o = 0; o < xbar_pkg::num_in; o++) begin : g_req_out
    for (genvar i = 0; i < xbar_pkg::num_in; i++) begin : g_req_in
      assign arb_reqs_o[o][i] = head_v_i[i] &&
        (head_data_i[i][xbar_pkg::lg_num_in-1:0] == (xbar_pkg::lg_num_in)'(o));
    end
  end

  always_comb begin
    out_v_o      = '0;
    out_data_o   = '0;
    arb_accept_o = '0;
    head_yumi_o  = '0;
    for (int o = 0; o < xbar_pkg::num_in; o++) begin
      out_v_o[o]      = |arb_grants_i[o];
      arb_accept_o[o] = out_v_o[o] & out_ready_i[o];
      for (int i = 0; i < xbar_pkg::num_in; i++) begin
        // Grants are one-hot so an OR mux is enough
        if (arb_grants_i[o][i]) begin
          out_data_o[o] = out_data_o[o] | head_data_i[i];
        end
        head_yumi_o[i] = head_yumi_o[i] | (arb_grants_i[o][i] & out_ready_i[o]);
      end
    end
  end

endmodule

//--- tests/xbar_tb.sv
`timescale 1ns/1ps

module xbar_tb;

  localparam int random_words = 2000;
  localparam int flood_words  = 200;
  localparam int bp_words     = 400;
  localparam int hold_cycles  = 50;
  localparam int wait_limit   = 20000;
  localparam int blocked_lane = 3;
  localparam int seq_width    = xbar_pkg::link_width - xbar_pkg::lg_num_in
                                - xbar_pkg::x_cord_width - xbar_pkg::y_cord_width;
  localparam logic [xbar_pkg::num_in-1:0] aimed_mask = 4'b0011;

  typedef enum int {
    traffic_idle,
    traffic_random,
    traffic_flood,
    traffic_backpressure
  } traffic_e;

  logic                                                   clk_i;
  logic                                                   reset_i;
  logic [xbar_pkg::num_in-1:0]                            link_v_i = '0;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_i = '0;
  logic [xbar_pkg::num_in-1:0]                            link_ready_o;
  logic [xbar_pkg::num_in-1:0]                            link_v_o;
  logic [xbar_pkg::num_in-1:0][xbar_pkg::link_width-1:0] link_data_o;
  logic [xbar_pkg::num_in-1:0]                            link_ready_i = '1;

  // Expected words, one queue per destination and source pair
  logic [xbar_pkg::link_width-1:0] model_q [xbar_pkg::num_in*xbar_pkg::num_in][$];
  logic [seq_width-1:0]            seq_r [xbar_pkg::num_in];
  logic [xbar_pkg::link_width-1:0] prev_data [xbar_pkg::num_in];
  logic [xbar_pkg::num_in-1:0]     prev_hold;
  logic [xbar_pkg::num_in-1:0]     fired_in;
  logic [xbar_pkg::num_in-1:0]     hold_low;
  int                              out_count [xbar_pkg::num_in];
  int                              flood_src [$];
  int                              words_left;
  bit                              flood_active;
  traffic_e                        mode;

  manycore_xbar_top uut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic value_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    fail_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    fail_run();
  endtask

  // Upper payload bits carry the source lane, the rest a sequence count
  function automatic logic [xbar_pkg::link_width-1:0] make_word(
    input int src, input logic [seq_width-1:0] seq, input int dest);
    logic [xbar_pkg::x_cord_width-1:0] x;
    logic [xbar_pkg::y_cord_width-1:0] y;
    x = (xbar_pkg::x_cord_width)'(dest % xbar_pkg::num_in_x);
    y = (xbar_pkg::y_cord_width)'(dest / xbar_pkg::num_in_x);
    return {(xbar_pkg::lg_num_in)'(src), seq, y, x};
  endfunction

  function automatic int word_lane(input logic [xbar_pkg::link_width-1:0] word);
    int x;
    int y;
    x = int'(word[0+:xbar_pkg::x_cord_width]);
    y = int'(word[xbar_pkg::x_cord_width+:xbar_pkg::y_cord_width]);
    return y * xbar_pkg::num_in_x + x;
  endfunction

  function automatic int word_src(input logic [xbar_pkg::link_width-1:0] word);
    return int'(word[xbar_pkg::link_width-1-:xbar_pkg::lg_num_in]);
  endfunction

  function automatic bit queues_empty();
    for (int q = 0; q < xbar_pkg::num_in * xbar_pkg::num_in; q++) begin
      if (model_q[q].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic bit drained();
    if (words_left != 0 || link_v_i != '0) begin
      return 1'b0;
    end
    return queues_empty();
  endfunction

  task automatic check_link_word(input logic [xbar_pkg::lg_num_in-1:0] lane,
                                 input logic [xbar_pkg::link_width-1:0] word);
    int                              idx;
    logic [xbar_pkg::link_width-1:0] exp;
    if (word_lane(word) != int'(lane)) begin
      value_error($sformatf("word %h left at lane %0d but names lane %0d",
                            word, lane, word_lane(word)));
    end
    idx = int'(lane) * xbar_pkg::num_in + word_src(word);
    if (model_q[idx].size() == 0) begin
      value_error($sformatf("lane %0d delivered unexpected word %h", lane, word));
    end else begin
      exp = model_q[idx].pop_front();
      if (word !== exp) begin
        value_error($sformatf("lane %0d delivered %h, expected %h", lane, word, exp));
      end
    end
  endtask

  task automatic check_held_word(input logic [xbar_pkg::lg_num_in-1:0] lane,
                                 input logic v,
                                 input logic [xbar_pkg::link_width-1:0] got,
                                 input logic [xbar_pkg::link_width-1:0] exp);
    if (v !== 1'b1 || got !== exp) begin
      value_error($sformatf("held lane %0d changed to v=%b data=%h, expected %h",
                            lane, v, got, exp));
    end
  endtask

  task automatic check_lane_idle(input logic [xbar_pkg::num_in-1:0] v_bits);
    if (v_bits !== '0) begin
      value_error($sformatf("valid bits %b while idle", v_bits));
    end
  endtask

  task automatic check_ready_bits(input logic [xbar_pkg::num_in-1:0] got,
                                  input logic [xbar_pkg::num_in-1:0] exp);
    if (got !== exp) begin
      value_error($sformatf("link_ready_o is %b, expected %b", got, exp));
    end
  endtask

  // Every source stays busy during the flood, so each window holds all of them
  task automatic check_flood_window();
    logic [xbar_pkg::num_in-1:0] seen;
    int                          n;
    seen = '0;
    n = flood_src.size();
    if (n >= xbar_pkg::num_in) begin
      for (int k = n - xbar_pkg::num_in; k < n; k++) begin
        seen[flood_src[k]] = 1'b1;
      end
      if (seen != '1) begin
        value_error($sformatf("unfair window at lane 0, sources seen %b", seen));
      end
    end
  endtask

  task automatic start_word(input int src, input int dest);
    link_data_i[src] = make_word(src, seq_r[src], dest);
    link_v_i[src]    = 1'b1;
    seq_r[src]       = seq_r[src] + 1'b1;
  endtask

  task automatic drive_sources();
    int dest;
    for (int l = 0; l < xbar_pkg::num_in; l++) begin
      // A pending word stays put until it transfers
      if (!link_v_i[l] || fired_in[l]) begin
        link_v_i[l] = 1'b0;
        if (mode == traffic_flood) begin
          start_word(l, 0);
        end else if (mode != traffic_idle && words_left > 0 &&
                     $urandom_range(3, 0) != 0) begin
          if (mode == traffic_backpressure) begin
            dest = (l < 2) ? blocked_lane : int'($urandom_range(2, 0));
          end else begin
            dest = int'($urandom_range(xbar_pkg::num_in - 1, 0));
          end
          start_word(l, dest);
          words_left--;
        end
      end
    end
  endtask

  task automatic drive_sinks();
    for (int l = 0; l < xbar_pkg::num_in; l++) begin
      if (hold_low[l]) begin
        link_ready_i[l] = 1'b0;
      end else if (mode == traffic_flood && l == 0) begin
        link_ready_i[l] = 1'b1;
      end else begin
        link_ready_i[l] = ($urandom_range(3, 0) != 0);
      end
    end
  endtask

  always @(posedge clk_i) begin : drive_inputs
    logic was_reset;
    was_reset = reset_i;
    #1;
    if (was_reset) begin
      for (int l = 0; l < xbar_pkg::num_in; l++) begin
        seq_r[l] = '0;
      end
    end else begin
      drive_sources();
      drive_sinks();
    end
  end

  // Sampled half a cycle ahead of the edge where the transfers happen
  always @(negedge clk_i) begin : monitor
    logic [xbar_pkg::link_width-1:0] word;
    if (reset_i) begin
      fired_in  = '0;
      prev_hold = '0;
      for (int o = 0; o < xbar_pkg::num_in; o++) begin
        out_count[o] = 0;
      end
    end else begin
      fired_in = link_v_i & link_ready_o;
      for (int l = 0; l < xbar_pkg::num_in; l++) begin
        if (fired_in[l]) begin
          model_q[word_lane(link_data_i[l]) * xbar_pkg::num_in + l].push_back(link_data_i[l]);
        end
      end
      for (int o = 0; o < xbar_pkg::num_in; o++) begin
        word = link_data_o[o];
        if (prev_hold[o]) begin
          check_held_word((xbar_pkg::lg_num_in)'(o), link_v_o[o], word, prev_data[o]);
        end
        if (link_v_o[o] && link_ready_i[o]) begin
          if (flood_active && o == 0 && flood_src.size() < flood_words) begin
            flood_src.push_back(word_src(word));
            check_flood_window();
          end
          check_link_word((xbar_pkg::lg_num_in)'(o), word);
          out_count[o]++;
        end
        prev_hold[o] = link_v_o[o] && !link_ready_i[o];
        prev_data[o] = word;
      end
    end
  end

  task automatic wait_drained(input string phase);
    int cycles;
    for (cycles = 0; cycles < wait_limit && !drained(); cycles++) begin
      @(posedge clk_i);
    end
    if (!drained()) begin
      report_failure($sformatf("Timed out waiting for the %s traffic to drain", phase));
    end
  endtask

  initial begin : main
    int                          cycles;
    int                          flowed;
    logic [xbar_pkg::num_in-1:0] fell;
    void'($urandom(32'ha8c0d7db));
    reset_i      = 1'b1;
    mode         = traffic_idle;
    words_left   = 0;
    hold_low     = '0;
    flood_active = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    check_lane_idle(link_v_o);
    check_ready_bits(link_ready_o, '1);

    words_left = random_words;
    mode       = traffic_random;
    wait_drained("random");
    mode = traffic_idle;

    // All sources aim at lane 0
    flood_active = 1'b1;
    mode         = traffic_flood;
    for (cycles = 0; cycles < wait_limit && flood_src.size() < flood_words; cycles++) begin
      @(posedge clk_i);
    end
    if (flood_src.size() < flood_words) begin
      report_failure("Timed out waiting for flood transfers at lane 0");
    end
    flood_active = 1'b0;
    mode         = traffic_idle;
    wait_drained("flood");

    // Lane 3 refuses words while the other lanes keep trading
    words_left = bp_words;
    hold_low   = '0;
    hold_low[blocked_lane] = 1'b1;
    mode       = traffic_backpressure;
    flowed     = out_count[0] + out_count[1] + out_count[2];
    fell       = '0;
    for (cycles = 0; cycles < hold_cycles; cycles++) begin
      @(negedge clk_i);
      fell = fell | ~link_ready_o;
    end
    hold_low = '0;
    if ((fell & aimed_mask) != aimed_mask) begin
      report_failure("link_ready_o never fell for the sources aimed at the blocked lane");
    end
    if (out_count[0] + out_count[1] + out_count[2] == flowed) begin
      report_failure("No traffic moved between the other lanes while one lane was blocked");
    end
    wait_drained("back-pressure");
    mode = traffic_idle;
    @(negedge clk_i);
    check_lane_idle(link_v_o);

    if (queues_empty()) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("Model queues still hold words after the final drain");
    end
  end

endmodule

//--- verilog.f
src/xbar_pkg.sv
src/link_to_crossbar.sv
src/xbar_fifo.sv
src/xbar_rr_arbiter.sv
src/xbar_switch.sv
src/manycore_xbar_top.sv
tests/xbar_tb.sv
